// File: common/scan_pkg.sv
package scan_pkg;

  // Stream id width and number of per-stream slots
  localparam int STREAM_W    = 6;
  localparam int NUM_STREAMS = 64;

  // Automaton state and per-rule packet count widths
  localparam int STATE_W = 4;
  localparam int COUNT_W = 16;

  // Rule matchers and longest pattern they accept
  localparam int NUM_RULES = 2;
  localparam int MAX_PAT   = 8;

  // Patterns packed with the first byte in the lowest byte lane
  // "NBSS"
  localparam logic [8*MAX_PAT-1:0] RULE0_PATTERN = 64'h0000_0000_5353_424E;
  localparam int                   RULE0_LEN     = 4;
  // "SMB"
  localparam logic [8*MAX_PAT-1:0] RULE1_PATTERN = 64'h0000_0000_0042_4D53;
  localparam int                   RULE1_LEN     = 3;

  // Cycles from the eop beat to the pkt_done pulse
  localparam int MATCH_LAT = 3;

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Register map
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_CLEAR  = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_COUNT0 = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_COUNT1 = 8'h0C;

endpackage

// File: hdl/substring_dfa.sv
`timescale 1ns/1ps

module substring_dfa #(
  parameter logic [8*scan_pkg::MAX_PAT-1:0] PATTERN     = scan_pkg::RULE0_PATTERN,
  parameter int                             PATTERN_LEN = scan_pkg::RULE0_LEN
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [7:0]                  char_in,
  input  logic                        char_vld,
  input  logic                        load,
  input  logic [scan_pkg::STATE_W-1:0] state_in,
  output logic [scan_pkg::STATE_W-1:0] state_out,
  output logic                        accept
);

  logic [scan_pkg::STATE_W-1:0] state_q;
  logic [scan_pkg::STATE_W-1:0] cur_state;
  logic [scan_pkg::STATE_W-1:0] next_state;
  logic [7:0]                   pat_byte;
  logic                         accept_d;
  logic                         accept_q;

  // A load beat continues from the restored state, not our own register
  assign cur_state = load ? state_in : state_q;

  // Pattern byte expected at the current state
  always_comb
  begin
    pat_byte = 8'h00;
    for (int i = 0; i < scan_pkg::MAX_PAT; i++)
    begin
      if (cur_state == scan_pkg::STATE_W'(i))
        pat_byte = PATTERN[8*i +: 8];
    end
  end

  // Transition rule, exact only for patterns without self-overlap
  always_comb
  begin
    accept_d = 1'b0;
    if (char_in == pat_byte)
      next_state = cur_state + 1'b1;
    else if (char_in == PATTERN[7:0])
      next_state = scan_pkg::STATE_W'(1);
    else
      next_state = '0;
    // Full pattern seen, report and start over
    if (next_state == scan_pkg::STATE_W'(PATTERN_LEN))
    begin
      accept_d   = 1'b1;
      next_state = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= '0;
      accept_q <= 1'b0;
    end
    else
    begin
      // Accept only lives for the byte that completed the pattern
      accept_q <= char_vld & accept_d;
      if (char_vld)
        state_q <= next_state;
      else if (load)
        state_q <= state_in;
    end
  end

  assign state_out = state_q;
  assign accept    = accept_q;

  a_state_below_len: assert property (@(posedge clk) disable iff (!rst_n)
    state_out < scan_pkg::STATE_W'(PATTERN_LEN));

endmodule

// File: rule_matcher/rule_matcher.sv
`timescale 1ns/1ps

module rule_matcher #(
  parameter logic [8*scan_pkg::MAX_PAT-1:0] PATTERN     = scan_pkg::RULE0_PATTERN,
  parameter int                             PATTERN_LEN = scan_pkg::RULE0_LEN
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [7:0]                   char_in,
  input  logic                         char_vld,
  input  logic                         eop,
  input  logic                         load_state,
  input  logic                         new_stream,
  input  logic [scan_pkg::STREAM_W-1:0] stream_id,
  input  logic                         enable,
  output logic                         pkt_done,
  output logic                         matched,
  output logic [scan_pkg::COUNT_W-1:0]  count
);

  // Saved automaton state per stream
  logic [scan_pkg::STATE_W-1:0] state_mem [scan_pkg::NUM_STREAMS];

  // Stage 1 registers
  logic [7:0]                    char_s1;
  logic                          vld_s1;
  logic                          eop_s1;
  logic                          load_s1;
  logic [scan_pkg::STREAM_W-1:0] sid_s1;
  logic [scan_pkg::STATE_W-1:0]  restore_s1;

  // Stage 2 registers next to the automaton
  logic                          eop_s2;
  logic                          load_s2;
  logic [scan_pkg::STREAM_W-1:0] sid_s2;

  // Automaton outputs
  logic [scan_pkg::STATE_W-1:0] dfa_state;
  logic                         dfa_accept;

  // Per-packet sticky match flag
  logic flag_q;
  logic flag_next;
  logic hit;
  logic save;

  // Input side packet tracking for the framing check
  logic pkt_open;

  // Stage 1 captures the beat and fetches the state to restore
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      vld_s1  <= 1'b0;
      eop_s1  <= 1'b0;
      load_s1 <= 1'b0;
    end
    else
    begin
      vld_s1  <= char_vld;
      eop_s1  <= eop;
      load_s1 <= load_state;
    end
  end

  always_ff @(posedge clk)
  begin
    char_s1 <= char_in;
    sid_s1  <= stream_id;
    // New streams start from scratch
    if (load_state)
      restore_s1 <= new_stream ? '0 : state_mem[stream_id];
  end

  // Stage 2 side band
  // Stream id must outlive the input once the packet ends
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      eop_s2  <= 1'b0;
      load_s2 <= 1'b0;
    end
    else
    begin
      eop_s2  <= eop_s1;
      load_s2 <= load_s1;
    end
  end

  always_ff @(posedge clk)
  begin
    sid_s2 <= sid_s1;
  end

  substring_dfa #(
    .PATTERN     (PATTERN),
    .PATTERN_LEN (PATTERN_LEN)
  ) i_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_in   (char_s1),
    .char_vld  (vld_s1),
    .load      (load_s1),
    .state_in  (restore_s1),
    .state_out (dfa_state),
    .accept    (dfa_accept)
  );

  // Flag restarts with each packet
  // An accept on the eop byte still lands here
  assign flag_next = (load_s2 ? 1'b0 : flag_q) | dfa_accept;
  assign hit       = eop_s2 & enable & flag_next;
  assign save      = eop_s2 & enable;

  // Stage 3 packet result and count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      flag_q   <= 1'b0;
      pkt_done <= 1'b0;
      matched  <= 1'b0;
      count    <= '0;
    end
    else
    begin
      flag_q   <= flag_next;
      pkt_done <= eop_s2;
      matched  <= hit;
      if (hit)
        count <= count + 1'b1;
    end
  end

  // Single write port for the state memory
  // Save at the delayed eop, or zero the slot of a new stream
  // Idle spacing between packets keeps the two apart
  always_ff @(posedge clk)
  begin
    if (save)
      state_mem[sid_s2] <= dfa_state;
    else if (load_state && new_stream)
      state_mem[stream_id] <= '0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pkt_open <= 1'b0;
    else if (load_state && !eop)
      pkt_open <= 1'b1;
    else if (eop)
      pkt_open <= 1'b0;
  end

  // Every eop needs a load since the previous eop
  a_eop_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    eop |-> (load_state || pkt_open));

endmodule

// File: hdl/stream_tracker.sv
`timescale 1ns/1ps

module stream_tracker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         sop,
  input  logic                         eop,
  input  logic [scan_pkg::STREAM_W-1:0] stream_id,
  input  logic                         clear_streams,
  output logic                         load_state,
  output logic                         new_stream
);

  // One bit per stream id, set once the id has carried a packet
  logic [scan_pkg::NUM_STREAMS-1:0] seen;

  // Packet in progress, only used for framing checks
  logic pkt_open;

  // Matchers restore state on the first beat
  assign load_state = sop;

  // Unseen id means the saved state is stale or absent
  assign new_stream = sop & ~seen[stream_id];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      seen <= '0;
    else if (clear_streams)
      // Clear wins over a mark on the same edge
      seen <= '0;
    else if (sop)
      seen[stream_id] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pkt_open <= 1'b0;
    else if (sop && !eop)
      pkt_open <= 1'b1;
    else if (eop)
      pkt_open <= 1'b0;
  end

  // No new packet may start before the last one closed
  a_no_nested_sop: assert property (@(posedge clk) disable iff (!rst_n)
    sop |-> !pkt_open);

endmodule

// File: hdl/scan_apb_regs.sv
`timescale 1ns/1ps

module scan_apb_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [scan_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [scan_pkg::APB_DATA_W-1:0] pwdata,
  input  logic [scan_pkg::COUNT_W-1:0]    count0,
  input  logic [scan_pkg::COUNT_W-1:0]    count1,
  output logic [scan_pkg::APB_DATA_W-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic [scan_pkg::NUM_RULES-1:0]  enable,
  output logic                           clear_streams
);

  logic apb_write;
  logic addr_hit;

  // Zero wait states
  assign pready = 1'b1;

  // Access phase of a write
  assign apb_write = psel & penable & pwrite;

  // Read mux and address decode
  always_comb
  begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      scan_pkg::ADDR_CTRL:
        prdata = {{(scan_pkg::APB_DATA_W-scan_pkg::NUM_RULES){1'b0}}, enable};
      // Clear is write-only, reads back zero
      scan_pkg::ADDR_CLEAR:
        prdata = '0;
      scan_pkg::ADDR_COUNT0:
        prdata = {{(scan_pkg::APB_DATA_W-scan_pkg::COUNT_W){1'b0}}, count0};
      scan_pkg::ADDR_COUNT1:
        prdata = {{(scan_pkg::APB_DATA_W-scan_pkg::COUNT_W){1'b0}}, count1};
      default:
        addr_hit = 1'b0;
    endcase
  end

  // Error only during the access phase of an unmapped address
  assign pslverr = psel & penable & ~addr_hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable        <= '0;
      clear_streams <= 1'b0;
    end
    else
    begin
      // Single cycle strobe after the write
      clear_streams <= apb_write & (paddr == scan_pkg::ADDR_CLEAR) & pwdata[0];
      if (apb_write && paddr == scan_pkg::ADDR_CTRL)
        enable <= pwdata[scan_pkg::NUM_RULES-1:0];
      // Count addresses are read-only, writes fall through
    end
  end

  a_penable_with_psel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel);

endmodule

// File: hdl/packet_scanner_top.sv
`timescale 1ns/1ps

module packet_scanner_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // Byte lane
  input  logic                           sop,
  input  logic                           eop,
  input  logic                           byte_vld,
  input  logic [7:0]                     byte_in,
  input  logic [scan_pkg::STREAM_W-1:0]   stream_id,
  // APB slave
  input  logic [scan_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [scan_pkg::APB_DATA_W-1:0] pwdata,
  output logic [scan_pkg::APB_DATA_W-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  // Packet results
  output logic                           pkt_done,
  output logic [scan_pkg::NUM_RULES-1:0]  pkt_match
);

  logic                          load_state;
  logic                          new_stream;
  logic                          clear_streams;
  logic [scan_pkg::NUM_RULES-1:0] enable;
  logic [scan_pkg::COUNT_W-1:0]   count0;
  logic [scan_pkg::COUNT_W-1:0]   count1;

  stream_tracker i_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .sop           (sop),
    .eop           (eop),
    .stream_id     (stream_id),
    .clear_streams (clear_streams),
    .load_state    (load_state),
    .new_stream    (new_stream)
  );

  // Both matchers share the pipeline, so rule 0 provides pkt_done
  rule_matcher #(
    .PATTERN     (scan_pkg::RULE0_PATTERN),
    .PATTERN_LEN (scan_pkg::RULE0_LEN)
  ) i_rule0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_in    (byte_in),
    .char_vld   (byte_vld),
    .eop        (eop),
    .load_state (load_state),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .enable     (enable[0]),
    .pkt_done   (pkt_done),
    .matched    (pkt_match[0]),
    .count      (count0)
  );

  rule_matcher #(
    .PATTERN     (scan_pkg::RULE1_PATTERN),
    .PATTERN_LEN (scan_pkg::RULE1_LEN)
  ) i_rule1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_in    (byte_in),
    .char_vld   (byte_vld),
    .eop        (eop),
    .load_state (load_state),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .enable     (enable[1]),
    .pkt_done   (),
    .matched    (pkt_match[1]),
    .count      (count1)
  );

  scan_apb_regs i_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .count0        (count0),
    .count1        (count1),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .enable        (enable),
    .clear_streams (clear_streams)
  );

endmodule

// File: test/scanner_tb.sv
`timescale 1ns/1ps

module scanner_tb;

  localparam int POOL_SIZE   = 4;
  localparam int IDLE_GAP    = 4;
  localparam int DRAIN_LIMIT = 64;
  localparam int READY_LIMIT = 8;

  logic                            clk;
  logic                            rst_n;
  logic                            sop;
  logic                            eop;
  logic                            byte_vld;
  logic [7:0]                      byte_in;
  logic [scan_pkg::STREAM_W-1:0]   stream_id;
  logic [scan_pkg::APB_ADDR_W-1:0] paddr;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [scan_pkg::APB_DATA_W-1:0] pwdata;
  logic [scan_pkg::APB_DATA_W-1:0] prdata;
  logic                            pready;
  logic                            pslverr;
  logic                            pkt_done;
  logic [scan_pkg::NUM_RULES-1:0]  pkt_match;

  int seed = 93;

  // Reference model state per rule and stream
  int                             model_state [scan_pkg::NUM_RULES][scan_pkg::NUM_STREAMS];
  bit                             model_seen [scan_pkg::NUM_STREAMS];
  int                             model_count [scan_pkg::NUM_RULES];
  logic [scan_pkg::NUM_RULES-1:0] model_en;

  // Bytes of the packet about to be sent
  logic [7:0] pkt_bytes [$];
  // Predicted results and eop cycles still waiting for pkt_done
  logic [scan_pkg::NUM_RULES-1:0] exp_match [$];
  int                             eop_cycles [$];
  int                             cycle;
  logic [scan_pkg::NUM_RULES-1:0] last_match;
  logic [31:0]                    rdata;
  logic                           rerr;
  logic [31:0]                    count1_before;

  // Small id pool so stream states carry over between packets
  int pool [POOL_SIZE] = '{3, 17, 42, 63};

  packet_scanner_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .sop       (sop),
    .eop       (eop),
    .byte_vld  (byte_vld),
    .byte_in   (byte_in),
    .stream_id (stream_id),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .pkt_done  (pkt_done),
    .pkt_match (pkt_match)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %0h actual %0h", name, expected, actual));
  endtask

  // Patterns with the first byte at index 0
  function automatic logic [7:0] pattern_byte(input int rule, input int idx);
    string p;
    p = (rule == 0) ? "NBSS" : "SMB";
    return p[idx];
  endfunction

  function automatic int pattern_len(input int rule);
    return (rule == 0) ? 4 : 3;
  endfunction

  // Run the packet through the model and queue the expected result
  task automatic predict_packet(input int sid);
    int                             st;
    int                             nxt;
    bit                             flag;
    logic [scan_pkg::NUM_RULES-1:0] m;
    m = '0;
    // Unseen stream starts over in every rule whether enabled or not
    if (!model_seen[sid])
    begin
      for (int r = 0; r < scan_pkg::NUM_RULES; r++)
        model_state[r][sid] = 0;
    end
    model_seen[sid] = 1'b1;
    for (int r = 0; r < scan_pkg::NUM_RULES; r++)
    begin
      st   = model_state[r][sid];
      flag = 1'b0;
      foreach (pkt_bytes[i])
      begin
        if (pkt_bytes[i] == pattern_byte(r, st))
          nxt = st + 1;
        else if (pkt_bytes[i] == pattern_byte(r, 0))
          nxt = 1;
        else
          nxt = 0;
        if (nxt == pattern_len(r))
        begin
          flag = 1'b1;
          nxt  = 0;
        end
        st = nxt;
      end
      // Disabled rule keeps its saved state and count
      if (model_en[r])
      begin
        model_state[r][sid] = st;
        model_count[r]      = model_count[r] + int'(flag);
        m[r]                = flag;
      end
    end
    exp_match.push_back(m);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    sop      <= 1'b0;
    eop      <= 1'b0;
    byte_vld <= 1'b0;
    byte_in  <= 8'h00;
  endtask

  task automatic send_packet(input int sid, input bit with_gaps);
    int gap;
    predict_packet(sid);
    for (int i = 0; i < pkt_bytes.size(); i++)
    begin
      // Empty beats only between the first and last byte
      gap = (with_gaps && i > 0) ? int'($unsigned($random(seed)) % 3) : 0;
      repeat (gap) drive_idle();
      @(posedge clk);
      sop       <= (i == 0);
      eop       <= (i == pkt_bytes.size() - 1);
      byte_vld  <= 1'b1;
      byte_in   <= pkt_bytes[i];
      stream_id <= scan_pkg::STREAM_W'(sid);
    end
    repeat (IDLE_GAP) drive_idle();
  endtask

  task automatic load_text(input string s);
    pkt_bytes.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_bytes.push_back(s[i]);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_match.size() != 0)
    begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_LIMIT)
        abort_run("Timed out waiting for outstanding packet results");
    end
  endtask

  // Send one packet on its own and check the result seen on pkt_match
  task automatic directed_packet(input string name, input int sid, input string text,
                                 input logic [scan_pkg::NUM_RULES-1:0] expected);
    load_text(text);
    send_packet(sid, 1'b0);
    wait_drain();
    check_value(name, expected, last_match);
  endtask

  task automatic random_batch(input int num);
    int    sid;
    int    len;
    string alphabet;
    alphabet = "NBSMX";
    repeat (num)
    begin
      sid = pool[$unsigned($random(seed)) % POOL_SIZE];
      len = 1 + int'($unsigned($random(seed)) % 12);
      pkt_bytes.delete();
      repeat (len) pkt_bytes.push_back(alphabet[$unsigned($random(seed)) % 5]);
      send_packet(sid, 1'b1);
    end
    wait_drain();
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic err);
    int waited;
    @(posedge clk);
    paddr   <= addr;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // Access phase sampled at the falling edge
    @(negedge clk);
    waited = 0;
    while (pready !== 1'b1)
    begin
      waited++;
      if (waited > READY_LIMIT)
        abort_run("Timed out waiting for pready");
      @(negedge clk);
    end
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, wdata, unused, err);
    check_value("write pslverr", 0, err);
    if (addr == scan_pkg::ADDR_CTRL)
      model_en = wdata[scan_pkg::NUM_RULES-1:0];
    // Clear forgets every stream id
    if (addr == scan_pkg::ADDR_CLEAR && wdata[0])
    begin
      foreach (model_seen[i])
        model_seen[i] = 1'b0;
    end
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_value({name, " pslverr"}, 0, err);
    check_value(name, expected, data);
  endtask

  task automatic check_counts();
    read_check("count0", scan_pkg::ADDR_COUNT0, model_count[0]);
    read_check("count1", scan_pkg::ADDR_COUNT1, model_count[1]);
  endtask

  // Result monitor with exact latency from the eop beat
  always @(negedge clk)
  begin
    cycle = cycle + 1;
    if (rst_n && eop)
      eop_cycles.push_back(cycle);
    if (pkt_done)
    begin
      if (eop_cycles.size() == 0 || exp_match.size() == 0)
        abort_run("pkt_done pulsed with no packet outstanding");
      else
      begin
        check_value("pkt_done latency", scan_pkg::MATCH_LAT, cycle - eop_cycles.pop_front());
        last_match = pkt_match;
        check_value("pkt_match", exp_match.pop_front(), pkt_match);
      end
    end
    else if (eop_cycles.size() != 0 && cycle - eop_cycles[0] >= scan_pkg::MATCH_LAT)
      abort_run("pkt_done did not arrive after an eop beat");
  end

  initial
  begin
    cycle      = 0;
    last_match = '0;
    model_en   = '0;
    foreach (model_count[r])
      model_count[r] = 0;
    foreach (model_seen[i])
      model_seen[i] = 1'b0;
    rst_n     = 1'b0;
    sop       = 1'b0;
    eop       = 1'b0;
    byte_vld  = 1'b0;
    byte_in   = 8'h00;
    stream_id = '0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Register block after reset
    read_check("reset count0", scan_pkg::ADDR_COUNT0, 0);
    read_check("reset count1", scan_pkg::ADDR_COUNT1, 0);
    read_check("reset ctrl", scan_pkg::ADDR_CTRL, 0);
    reg_write(scan_pkg::ADDR_CTRL, 32'h1);
    read_check("ctrl readback", scan_pkg::ADDR_CTRL, 32'h1);
    reg_write(scan_pkg::ADDR_CTRL, 32'h3);
    read_check("ctrl readback", scan_pkg::ADDR_CTRL, 32'h3);
    apb_access(1'b0, 8'h10, 32'h0, rdata, rerr);
    check_value("unmapped pslverr", 1, rerr);

    // Patterns split across packets
    directed_packet("split first half", 5, "XNB", 2'b00);
    directed_packet("split same stream", 5, "SS", 2'b01);
    directed_packet("split other first", 6, "XNB", 2'b00);
    directed_packet("split other stream", 7, "SS", 2'b00);
    directed_packet("rule1 first half", 8, "XS", 2'b00);
    directed_packet("rule1 same stream", 8, "MB", 2'b10);

    // Stream clear drops carried partial matches
    directed_packet("clear first half", 9, "XNB", 2'b00);
    reg_write(scan_pkg::ADDR_CLEAR, 32'h1);
    directed_packet("after clear", 9, "SS", 2'b00);

    random_batch(40);
    check_counts();

    // Rule 1 disabled while stream 10 keeps its saved state
    directed_packet("enable first half", 10, "SM", 2'b00);
    reg_write(scan_pkg::ADDR_CTRL, 32'h1);
    count1_before = model_count[1];
    directed_packet("disabled rule1", 10, "XXS", 2'b00);
    random_batch(25);
    read_check("count1 while disabled", scan_pkg::ADDR_COUNT1, count1_before);
    check_counts();
    reg_write(scan_pkg::ADDR_CTRL, 32'h3);
    directed_packet("rule1 re-enabled", 10, "B", 2'b10);

    // Rule 0 disabled over a batch
    reg_write(scan_pkg::ADDR_CTRL, 32'h2);
    random_batch(20);
    check_counts();
    reg_write(scan_pkg::ADDR_CTRL, 32'h3);
    random_batch(40);
    check_counts();

    $display("sim passed");
    $finish;
  end

endmodule

// File: tb.f
common/scan_pkg.sv
hdl/substring_dfa.sv
rule_matcher/rule_matcher.sv
hdl/stream_tracker.sv
hdl/scan_apb_regs.sv
hdl/packet_scanner_top.sv
test/scanner_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module scanner_tb -f tb.f -o scanner_sim
./obj_dir/scanner_sim 2>&1 | tee sim.log
if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
